/* elink_data_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_data_gen (
  input  logic         clk,
  input  logic         reset,
  input  logic         loop_en,
  input  logic [7:0]   packet_length,
  output logic         done,
  elink_fifo_if.writer tx
);

  typedef enum logic [1:0] {st_idle, st_sop, st_data, st_eop} state_t;

  state_t                 state;
  logic                   loop_en_q;
  logic [7:0]             byte_cnt;
  elink_pkg::elink_word_t word;

  always_comb
  begin
    case (state)
      st_sop:  word = '{delimiter: elink_pkg::delim_sop, data: 8'h00};
      st_eop:  word = '{delimiter: elink_pkg::delim_eop, data: 8'h00};
      default: word = '{delimiter: elink_pkg::delim_data, data: byte_cnt};
    endcase
  end

  assign tx.wr_data = word;
  assign tx.wr_en   = (state != st_idle) && !tx.full; // a full FIFO holds the word.
  assign done       = (state == st_eop) && tx.wr_en;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= st_idle;
      loop_en_q <= 1'b0;
      byte_cnt  <= '0;
    end
    else
    begin
      loop_en_q <= loop_en;
      case (state)
        st_idle:
          if (loop_en && !loop_en_q)
            state <= st_sop; // one packet per rising edge.
        st_sop:
          if (tx.wr_en)
          begin
            byte_cnt <= '0;
            state    <= (packet_length == 8'd0) ? st_eop : st_data;
          end
        st_data:
          if (tx.wr_en)
          begin
            byte_cnt <= byte_cnt + 8'd1;
            if (byte_cnt == packet_length - 8'd1)
              state <= st_eop;
          end
        default:
          if (tx.wr_en)
            state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* elink_dec8b10b.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_dec8b10b (
  input  logic       clk,
  input  logic       reset,
  input  logic       load,
  input  logic [9:0] symbol,
  output logic [7:0] byte_out,
  output logic       k_out,
  output logic       code_error
);

  logic       rd;
  logic [5:0] s6;
  logic [3:0] s4;
  logic [4:0] x;
  logic [2:0] y;
  logic       found6;
  logic       found4;
  logic       is_k28;
  logic       bad_disp;
  logic [3:0] ones;

  assign s6   = symbol[9:4];
  assign ones = 4'($countones(symbol));

  always_comb
  begin
    logic [5:0] c6;
    logic [3:0] c4;
    found6 = 1'b0;
    found4 = 1'b0;
    x      = '0;
    y      = '0;
    is_k28 = (s6 == elink_pkg::code_k28) || (s6 == ~elink_pkg::code_k28);
    for (int i = 0; i < 32; i++)
    begin
      c6 = elink_pkg::code_6b[i];
      if (s6 == c6 || ((($countones(c6) != 3) || i == 7) && s6 == ~c6))
      begin
        found6 = 1'b1;
        x      = 5'(i);
      end
    end
    if (is_k28)
    begin
      found6 = 1'b1;
      x      = 5'd28;
    end
    // K28 after its negative 6b block carries the flipped 4b code.
    s4 = (s6 == ~elink_pkg::code_k28) ? ~symbol[3:0] : symbol[3:0];
    for (int j = 0; j < 8; j++)
    begin
      c4 = elink_pkg::code_4b[j];
      if (s4 == c4 || ((($countones(c4) != 2) || j == 3) && s4 == ~c4))
      begin
        found4 = 1'b1;
        y      = 3'(j);
      end
    end
    if (s4 == elink_pkg::code_a7 || s4 == ~elink_pkg::code_a7)
    begin
      found4 = 1'b1;
      y      = 3'd7;
    end
    bad_disp = (ones > 4'd6) || (ones < 4'd4) ||
               (ones == 4'd6 && rd) || (ones == 4'd4 && !rd);
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      byte_out   <= {y, x};
      k_out      <= is_k28;
      code_error <= !found6 || !found4 || bad_disp;
    end
  end

  // the disparity follows the received symbol, so one error does not persist.
  always_ff @(posedge clk)
  begin
    if (reset)
      rd <= 1'b0;
    else if (load && ones != 4'd5)
      rd <= (ones > 4'd5);
  end

endmodule

`default_nettype wire

/* elink_enc8b10b.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_enc8b10b (
  input  logic       clk,
  input  logic       reset,
  input  logic       load,
  input  logic [7:0] byte_in,
  input  logic       k_in,
  output logic [9:0] symbol
);

  logic       rd;      // running disparity, 1 is positive.
  logic       rd6;     // disparity after the 6b sub-block.
  logic       rd_next;
  logic [4:0] x;
  logic [2:0] y;
  logic [5:0] code6;
  logic [3:0] code4;

  assign x = byte_in[4:0];
  assign y = byte_in[7:5];

  always_comb
  begin
    code6 = k_in ? elink_pkg::code_k28 : elink_pkg::code_6b[x];
    if (rd && (($countones(code6) != 3) || (!k_in && x == 5'd7)))
      code6 = ~code6;
    rd6 = ($countones(code6) == 3) ? rd : !rd;

    code4 = elink_pkg::code_4b[y];
    // the alternate x.7 code avoids a run of five equal bits across the sub-blocks.
    if (y == 3'd7 && (k_in ||
        (!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
        (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14))))
      code4 = elink_pkg::code_a7;
    if (rd6 && (($countones(code4) != 2) || y == 3'd3))
      code4 = ~code4;
    // K28 balanced codes are flipped against the data table when rd6 is negative.
    if (k_in && !rd6 && (y == 3'd1 || y == 3'd2 || y == 3'd5 || y == 3'd6))
      code4 = ~code4;
    rd_next = ($countones(code4) == 2) ? rd6 : !rd6;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      symbol <= {code6, code4};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      rd <= 1'b0; // negative after reset.
    else if (load)
      rd <= rd_next;
  end

endmodule

`default_nettype wire

/* elink_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_fifo #(
  parameter int  depth     = 16,
  parameter type payload_t = logic
) (
  input logic        clk,
  input logic        reset,
  elink_fifo_if.fifo bus
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign bus.full  = (count == cnt_w'(depth));
  assign bus.empty = (count == '0);
  assign do_wr     = bus.wr_en && !bus.full;  // writes into a full FIFO are lost.
  assign do_rd     = bus.rd_en && !bus.empty;

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= bus.wr_data;
    if (do_rd)
      bus.rd_data <= mem[rd_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap at depth, which need not be a power of two.
      if (do_wr)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* elink_fifo_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface elink_fifo_if #(
  parameter type payload_t = logic
) ();

  logic     wr_en;
  payload_t wr_data;
  logic     full;
  logic     rd_en;
  payload_t rd_data; // valid one cycle after rd_en.
  logic     empty;

  modport writer (output wr_en, output wr_data, input full);
  modport reader (output rd_en, input rd_data, input empty);
  modport fifo (
    input  wr_en,
    input  wr_data,
    input  rd_en,
    output full,
    output rd_data,
    output empty
  );

endinterface

`default_nettype wire

/* elink_loopback.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_loopback #(
  parameter int tx_depth = 16,
  parameter int rx_depth = 16
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       loop_en,
  input  logic [7:0] packet_length,
  output logic       done,
  output logic [1:0] elink_out,
  input  logic [1:0] elink_in,
  input  logic       rx_rd_en,
  output logic [7:0] rx_data,
  output logic [1:0] rx_delimiter,
  output logic       rx_code_error,
  output logic       rx_empty
);

  elink_fifo_if #(.payload_t(elink_pkg::elink_word_t))    tx_fifo_bus ();
  elink_fifo_if #(.payload_t(elink_pkg::elink_rx_word_t)) rx_fifo_bus ();

  elink_data_gen data_gen_i (
    .clk           (clk),
    .reset         (reset),
    .loop_en       (loop_en),
    .packet_length (packet_length),
    .done          (done),
    .tx            (tx_fifo_bus.writer)
  );

  elink_fifo #(.depth(tx_depth), .payload_t(elink_pkg::elink_word_t)) tx_fifo_i (
    .clk   (clk),
    .reset (reset),
    .bus   (tx_fifo_bus.fifo)
  );

  elink_tx tx_i (
    .clk       (clk),
    .reset     (reset),
    .tx        (tx_fifo_bus.reader),
    .elink_out (elink_out)
  );

  elink_rx rx_i (
    .clk      (clk),
    .reset    (reset),
    .elink_in (elink_in),
    .rx       (rx_fifo_bus.writer)
  );

  elink_fifo #(.depth(rx_depth), .payload_t(elink_pkg::elink_rx_word_t)) rx_fifo_i (
    .clk   (clk),
    .reset (reset),
    .bus   (rx_fifo_bus.fifo)
  );

  // the read side of the receive FIFO is the outside port.
  assign rx_fifo_bus.rd_en = rx_rd_en;
  assign rx_data           = rx_fifo_bus.rd_data.word.data;
  assign rx_delimiter      = rx_fifo_bus.rd_data.word.delimiter;
  assign rx_code_error     = rx_fifo_bus.rd_data.code_error;
  assign rx_empty          = rx_fifo_bus.empty;

endmodule

`default_nettype wire

/* elink_pkg.sv */
`default_nettype none

package elink_pkg;

  // delimiter codes carried next to every byte.
  localparam logic [1:0] delim_data = 2'b00;
  localparam logic [1:0] delim_sop  = 2'b01;
  localparam logic [1:0] delim_eop  = 2'b10; // 2'b11 is never written.

  localparam logic [7:0] k_comma = 8'hBC; // K28.5.
  localparam logic [7:0] k_sop   = 8'h3C; // K28.1.
  localparam logic [7:0] k_eop   = 8'hDC; // K28.6.

  // K28.5 with negative and positive symbol disparity, abcdei fghj with a in bit 9.
  localparam logic [9:0] comma_neg = 10'h305;
  localparam logic [9:0] comma_pos = 10'h0FA;

  // 5b/6b and 3b/4b codes for a negative running disparity.
  // the positive form is the complement for unbalanced codes, D.07 and D.x.3.
  localparam logic [5:0] code_6b [0:31] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };
  localparam logic [3:0] code_4b [0:7] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };
  localparam logic [5:0] code_k28 = 6'b001111;
  localparam logic [3:0] code_a7  = 4'b0111; // alternate D.x.7 and all K.x.7.

  typedef struct packed {
    logic [1:0] delimiter;
    logic [7:0] data;
  } elink_word_t;

  typedef struct packed {
    elink_word_t word;
    logic        code_error;
  } elink_rx_word_t;

endpackage

`default_nettype wire

/* elink_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_rx (
  input  logic         clk,
  input  logic         reset,
  input  logic [1:0]   elink_in,
  elink_fifo_if.writer rx
);

  logic [19:0]               hist;      // newest pair in the low bits.
  logic                      two_commas;
  logic                      locked;
  logic [2:0]                phase;     // 0 when a whole symbol sits in hist[9:0].
  logic                      dec_load;
  logic                      dec_valid;
  logic [7:0]                dec_byte;
  logic                      dec_k;
  logic                      dec_err;
  logic                      drop;
  elink_pkg::elink_rx_word_t word;

  function automatic logic is_comma(input logic [9:0] s);
    return (s == elink_pkg::comma_neg) || (s == elink_pkg::comma_pos);
  endfunction

  // checked every cycle, so the five pair offsets of a symbol are all tried.
  assign two_commas = is_comma(hist[19:10]) && is_comma(hist[9:0]);
  assign dec_load   = locked && (phase == 3'd0);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hist      <= '0;
      locked    <= 1'b0;
      phase     <= '0;
      dec_valid <= 1'b0;
    end
    else
    begin
      hist      <= {hist[17:0], elink_in};
      dec_valid <= dec_load;
      if (two_commas)
      begin
        locked <= 1'b1; // also realigns when the commas move.
        phase  <= 3'd1;
      end
      else
        phase <= (phase == 3'd4) ? 3'd0 : phase + 3'd1;
    end
  end

  elink_dec8b10b dec_i (
    .clk        (clk),
    .reset      (reset),
    .load       (dec_load),
    .symbol     (hist[9:0]),
    .byte_out   (dec_byte),
    .k_out      (dec_k),
    .code_error (dec_err)
  );

  always_comb
  begin
    drop = 1'b0;
    word = '{word: '{delimiter: elink_pkg::delim_data, data: dec_byte}, code_error: dec_err};
    if (dec_k && !dec_err)
    begin
      case (dec_byte)
        elink_pkg::k_comma: drop = 1'b1; // idles never reach the FIFO.
        elink_pkg::k_sop:   word.word = '{delimiter: elink_pkg::delim_sop, data: 8'h00};
        elink_pkg::k_eop:   word.word = '{delimiter: elink_pkg::delim_eop, data: 8'h00};
        default:            word.code_error = 1'b1;
      endcase
    end
  end

  assign rx.wr_data = word;
  assign rx.wr_en   = dec_valid && !drop && !rx.full;

endmodule

`default_nettype wire

/* elink_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module elink_tx (
  input  logic         clk,
  input  logic         reset,
  elink_fifo_if.reader tx,
  output logic [1:0]   elink_out
);

  logic [2:0]             pair_cnt;  // bit pair within the symbol on the line.
  logic                   have_word; // the FIFO was read for the next symbol.
  logic [7:0]             enc_byte;
  logic                   enc_k;
  logic [9:0]             enc_symbol;
  logic [9:0]             shreg;
  elink_pkg::elink_word_t word;

  assign word     = tx.rd_data;
  assign tx.rd_en = (pair_cnt == 3'd2) && !tx.empty;

  always_comb
  begin
    enc_k    = 1'b1;
    enc_byte = elink_pkg::k_comma; // idle fill.
    if (have_word)
    begin
      case (word.delimiter)
        elink_pkg::delim_sop: enc_byte = elink_pkg::k_sop;
        elink_pkg::delim_eop: enc_byte = elink_pkg::k_eop;
        default:
        begin
          enc_byte = word.data;
          enc_k    = 1'b0;
        end
      endcase
    end
  end

  elink_enc8b10b enc_i (
    .clk     (clk),
    .reset   (reset),
    .load    (pair_cnt == 3'd3),
    .byte_in (enc_byte),
    .k_in    (enc_k),
    .symbol  (enc_symbol)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pair_cnt  <= '0;
      have_word <= 1'b0;
      shreg     <= elink_pkg::comma_neg; // matches the negative disparity that follows.
    end
    else
    begin
      pair_cnt  <= (pair_cnt == 3'd4) ? 3'd0 : pair_cnt + 3'd1;
      have_word <= (pair_cnt == 3'd2) ? tx.rd_en : have_word;
      if (pair_cnt == 3'd4)
        shreg <= enc_symbol;
      else
        shreg <= {shreg[7:0], 2'b00};
    end
  end

  assign elink_out = shreg[9:8]; // msb first.

endmodule

`default_nettype wire

/* project.f */
elink_pkg.sv
elink_fifo_if.sv
elink_fifo.sv
elink_data_gen.sv
elink_enc8b10b.sv
elink_tx.sv
elink_dec8b10b.sv
elink_rx.sv
elink_loopback.sv
tb_clock_gen.sv
tb_elink_loopback.sv

/* run.sh */
#!/bin/sh
# builds the loopback testbench with Verilator, runs it and scans the log.
verilator --binary --timing --timescale 1ns/100ps --top-module tb_elink_loopback \
  -f project.f -o tb_elink_loopback > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_elink_loopback > sim.log 2>&1 || true
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int period_ns = 20
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk; // free running, both halves equal.
  end

endmodule

`default_nettype wire

/* tb_elink_loopback.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_elink_loopback;

  localparam int num_tests     = 6;
  localparam int settle_cycles = 60;  // enough for a relock and its stray words.
  localparam int word_timeout  = 100;

  // K28.1 for both running disparities, bit 9 goes out first.
  localparam logic [9:0] sop_neg = 10'h0F9;
  localparam logic [9:0] sop_pos = 10'h306;

  typedef struct packed {
    logic [7:0] len;
    logic       slip;
    logic [7:0] inj_word; // packet word whose symbol gets a bit pair inverted, 0 for none.
  } test_t;

  localparam test_t tests [num_tests] = '{
    '{8'd1,  1'b0, 8'd0},
    '{8'd4,  1'b0, 8'd0},
    '{8'd12, 1'b0, 8'd0},
    '{8'd40, 1'b0, 8'd0},  // longer than the transmit FIFO.
    '{8'd8,  1'b1, 8'd0},
    '{8'd16, 1'b1, 8'd5}
  };

  logic       clk;
  logic       reset;
  logic       loop_en;
  logic [7:0] packet_length;
  logic       rx_rd_en;
  logic [1:0] elink_in = 2'b00;
  logic       done;
  logic [1:0] elink_out;
  logic [7:0] rx_data;
  logic [1:0] rx_delimiter;
  logic       rx_code_error;
  logic       rx_empty;

  logic       slip;
  logic [7:0] inj_word;
  int         inj_pair;
  logic [1:0] line_q     = 2'b00;
  logic [9:0] line_win   = '0;
  logic       counting   = 1'b0;
  int         pairs_seen = 0;
  logic [7:0] target     = '0;
  int         hit_word   = 0;
  int         done_count = 0;
  int         errors     = 0;
  int         test_errors;
  int         passed     = 0;
  int         seed       = 64413;

  tb_clock_gen #(.period_ns(20)) clock_gen_i (.clk(clk));

  elink_loopback #(.tx_depth(16), .rx_depth(16)) elink_loopback_i (
    .clk           (clk),
    .reset         (reset),
    .loop_en       (loop_en),
    .packet_length (packet_length),
    .done          (done),
    .elink_out     (elink_out),
    .elink_in      (elink_in),
    .rx_rd_en      (rx_rd_en),
    .rx_data       (rx_data),
    .rx_delimiter  (rx_delimiter),
    .rx_code_error (rx_code_error),
    .rx_empty      (rx_empty)
  );

  // the line from elink_out back to elink_in, with the slip and the bit pair hit.
  always @(posedge clk)
  begin
    logic [1:0] pair;
    logic [9:0] window;
    int         word_idx;
    int         pair_idx;
    pair   = reset ? 2'b00 : (slip ? line_q : elink_out);
    window = {line_win[7:0], pair};
    line_q   <= elink_out;
    line_win <= window;
    if (window == sop_neg || window == sop_pos)
    begin
      counting   <= 1'b1; // the next pair opens word 1 of the packet.
      pairs_seen <= 0;
      target     <= inj_word;
      hit_word   <= 0;
    end
    else if (counting)
    begin
      word_idx = 1 + pairs_seen / 5;
      pair_idx = pairs_seen % 5;
      pairs_seen <= pairs_seen + 1;
      // only a 00 or 11 pair changes the symbol weight, so the error is always seen.
      if (target != 8'd0 && (pair == 2'b00 || pair == 2'b11) &&
          (word_idx > int'(target) || (word_idx == int'(target) && pair_idx >= inj_pair)))
      begin
        pair = ~pair;
        hit_word <= word_idx;
        target   <= 8'd0;
        counting <= 1'b0;
      end
    end
    elink_in <= pair;
  end

  always @(posedge clk)
  begin
    if (done)
      done_count <= done_count + 1;
  end

  task automatic check_value(input string name, input int got, input int expected);
    if (got != expected)
    begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  // waits up to limit cycles for a word, then reads it with the one-cycle latency.
  task automatic read_word(input int limit, output logic [1:0] delim, output logic [7:0] data,
                           output logic err, output logic ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    delim  = '0;
    data   = '0;
    err    = 1'b0;
    @(posedge clk);
    while (rx_empty && waited < limit)
    begin
      @(posedge clk);
      waited++;
    end
    if (!rx_empty)
    begin
      rx_rd_en <= 1'b1;
      @(posedge clk);
      rx_rd_en <= 1'b0;
      @(posedge clk);
      delim = rx_delimiter;
      data  = rx_data;
      err   = rx_code_error;
      ok    = 1'b1;
    end
  endtask

  task automatic run_test(input int t);
    logic [1:0] got_delim [64];
    logic [7:0] got_data [64];
    logic       got_err [64];
    logic [1:0] delim;
    logic [7:0] data;
    logic       err;
    logic       ok;
    int         len;
    int         idle_words;
    int         done_before;
    int         n_words;
    int         exp_delim;
    bit         quiet;
    len         = int'(tests[t].len);
    test_errors = 0;
    quiet       = 1'b0;
    // a moved line or a hit symbol may leave stray words behind.
    if (t > 0)
      quiet = (tests[t].slip == tests[t-1].slip) && (tests[t-1].inj_word == 8'd0);
    slip          <= tests[t].slip;
    inj_word      <= tests[t].inj_word;
    inj_pair      <= int'($unsigned($random(seed)) % 5);
    packet_length <= tests[t].len;
    repeat (settle_cycles) @(posedge clk);
    idle_words = 0;
    ok         = 1'b1;
    while (ok)
    begin
      read_word(0, delim, data, err, ok);
      if (ok)
        idle_words++;
    end
    if (quiet)
      check_value("words between packets", idle_words, 0);
    done_before = done_count;
    loop_en <= 1'b1;
    @(posedge clk);
    loop_en <= 1'b0;
    n_words = 0;
    ok      = 1'b1;
    while (ok && n_words < len + 2)
    begin
      read_word(word_timeout, delim, data, err, ok);
      if (ok)
      begin
        got_delim[n_words] = delim;
        got_data[n_words]  = data;
        got_err[n_words]   = err;
        n_words++;
      end
    end
    if (!ok)
    begin
      $display("test %0d: only %0d of %0d words arrived in time", t, n_words, len + 2);
      errors++;
      test_errors++;
    end
    for (int k = 0; k < n_words; k++)
    begin
      if (tests[t].inj_word != 8'd0 && (k == hit_word || k == hit_word + 1))
        continue;
      if (k == 0)
        exp_delim = int'(elink_pkg::delim_sop);
      else if (k == len + 1)
        exp_delim = int'(elink_pkg::delim_eop);
      else
        exp_delim = int'(elink_pkg::delim_data);
      check_value($sformatf("word %0d rx_delimiter", k), int'(got_delim[k]), exp_delim);
      check_value($sformatf("word %0d rx_data", k), int'(got_data[k]),
                  (k >= 1 && k <= len) ? k - 1 : 0);
      check_value($sformatf("word %0d rx_code_error", k), int'(got_err[k]), 0);
    end
    if (tests[t].inj_word != 8'd0)
    begin
      if (hit_word < 1 || hit_word > len + 1)
      begin
        $display("test %0d: the inverted bit pair did not land inside the packet", t);
        errors++;
        test_errors++;
      end
      else if (hit_word < n_words)
      begin
        err = got_err[hit_word];
        if (hit_word + 1 < n_words)
          err = err | got_err[hit_word + 1];
        check_value("rx_code_error at the hit symbol", int'(err), 1);
      end
    end
    check_value("done pulses", done_count - done_before, 1);
    if (test_errors == 0)
      passed++;
    $display("test %0d: length %0d, slip %0d, hit word %0d, %0d errors",
             t, len, tests[t].slip, (tests[t].inj_word != 8'd0) ? hit_word : 0, test_errors);
  endtask

  initial
  begin
    reset         = 1'b1;
    loop_en       = 1'b0;
    packet_length = 8'd0;
    rx_rd_en      = 1'b0;
    slip          = 1'b0;
    inj_word      = 8'd0;
    inj_pair      = 0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_tests, passed, num_tests - passed, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // budget of five cycles per symbol, plus time to align and settle for each test.
  initial
  begin
    int limit;
    limit = 16;
    for (int i = 0; i < num_tests; i++)
      limit = limit + (int'(tests[i].len) + 2) * 5 + 200;
    repeat (limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
